// File: memPkg.sv
package memPkg;

   // data of one load or store
   typedef logic [15:0] dataWord;

   // byte address, bit 0 must be clear for a word access
   typedef logic [15:0] memAddr;

   // address the decode stage puts on an inserted no-op
   localparam memAddr BUBBLE_ADDR = 16'hFFFF;

   // request from execute into the memory stage, and from there into the cache
   typedef struct packed {
      memAddr  addr;       // byte address from the ALU
      dataWord writeData;  // store data
      logic    read;       // load strobe
      logic    write;      // store strobe
   } memReq;

   // outcome of one completed operation
   typedef struct packed {
      dataWord readData;   // load data, zero on error
      logic    err;        // misaligned access
      logic    hit;        // served from the cache without a memory access
   } memResp;

   // miss handling sequence of the data cache
   typedef enum logic [2:0] {
      IDLE,        // waiting, tag compare on a new request
      WRITEBACK,   // start writing the dirty victim out
      WAITWB,      // victim write in flight
      FILL,        // start reading the missing word
      WAITFILL,    // read in flight
      RESPOND      // install line, pulse done
   } cacheState;

endpackage

// File: memStage.sv
`timescale 1ns/1ps

module memStage (
   input  logic           clk,
   input  logic           reset,
   input  memPkg::memReq  req,        // from execute, held while stalled
   output memPkg::memReq  cacheReq,   // strobes gated
   input  logic           cacheDone,
   input  memPkg::memResp cacheResp,
   output logic           stall,      // to the upstream pipeline
   output logic           opDone,     // one pulse per completed operation
   output memPkg::memResp stageResp
);
   import memPkg::*;

   // fixed answer for a misaligned access
   localparam memResp ALIGN_RESP = '{readData: '0, err: 1'b1, hit: 1'b0};

   logic bubble;        // no-op inserted upstream
   logic access;        // a real load or store
   logic misaligned;
   logic alignErr;
   logic cacheAccess;   // aligned access the cache must serve
   logic issue;         // first cycle of that access
   logic busy;          // cache access issued, waiting for done

   assign bubble      = (req.addr == BUBBLE_ADDR);
   assign access      = (req.read | req.write) & ~bubble;
   assign misaligned  = req.addr[0];   // words only
   assign alignErr    = access & misaligned;
   assign cacheAccess = access & ~misaligned;
   assign issue       = cacheAccess & ~busy;

   // address and data pass straight through, strobes only on issue
   always_comb begin
      cacheReq       = req;
      cacheReq.read  = req.read & issue;
      cacheReq.write = req.write & issue;
   end

   // held request in the done cycle sees busy still set, so no reissue
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (cacheDone) begin
         busy <= 1'b0;
      end else if (issue) begin
         busy <= 1'b1;
      end
   end

   // low in the done cycle, lets the upstream advance
   assign stall = cacheAccess & ~cacheDone;

   // alignment errors answered here, same cycle
   assign opDone    = alignErr | cacheDone;
   assign stageResp = alignErr ? ALIGN_RESP : cacheResp;

   // upstream never asks for a load and a store at once
   assert property (@(posedge clk) disable iff (reset) !(req.read && req.write))
      else $error("memStage: read and write set together");

   // upstream holds the request for as long as the stage stalls it
   assert property (@(posedge clk) disable iff (reset) stall |=> $stable(req))
      else $error("memStage: request changed while stalled");

endmodule

// File: dataCache.sv
`timescale 1ns/1ps

module dataCache #(
   parameter int CACHE_SETS = 32   // power of two
) (
   input  logic            clk,
   input  logic            reset,
   input  memPkg::memReq   cacheReq,
   output logic            cacheDone,
   output memPkg::memResp  cacheResp,
   output logic            memStart,
   output logic            memWrite,
   output memPkg::memAddr  memAddrOut,
   output memPkg::dataWord memData,
   input  logic            memValid,
   input  memPkg::dataWord memReadData
);
   import memPkg::*;

   // one word per line, index sits right above the byte bit
   localparam int INDEX_BITS = $clog2(CACHE_SETS);
   localparam int TAG_BITS   = 15 - INDEX_BITS;

   typedef logic [INDEX_BITS-1:0] setIndex;
   typedef logic [TAG_BITS-1:0]   lineTag;

   dataWord               dataArr [CACHE_SETS];
   lineTag                tagArr [CACHE_SETS];
   logic [CACHE_SETS-1:0] validArr;
   logic [CACHE_SETS-1:0] dirtyArr;

   cacheState state;
   cacheState nextState;

   memAddr  reqAddr;    // request latched in IDLE
   logic    reqWrite;
   logic    respHit;
   dataWord lineData;   // word returned, and installed on a miss

   setIndex newIdx;     // from the incoming request
   lineTag  newTag;
   setIndex reqIdx;     // from the latched request
   lineTag  reqTag;
   logic    access;
   logic    tagHit;
   logic    victimDirty;

   assign newIdx      = cacheReq.addr[INDEX_BITS:1];
   assign newTag      = cacheReq.addr[15:INDEX_BITS+1];
   assign reqIdx      = reqAddr[INDEX_BITS:1];
   assign reqTag      = reqAddr[15:INDEX_BITS+1];
   assign access      = cacheReq.read | cacheReq.write;
   assign tagHit      = validArr[newIdx] && (tagArr[newIdx] == newTag);
   assign victimDirty = validArr[newIdx] && dirtyArr[newIdx];

   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (access) begin
               if (tagHit) begin
                  nextState = RESPOND;
               end else if (victimDirty) begin
                  nextState = WRITEBACK;
               end else if (cacheReq.read) begin
                  nextState = FILL;
               end else begin
                  nextState = RESPOND;   // store miss, whole line is overwritten
               end
            end
         end
         WRITEBACK: nextState = WAITWB;
         WAITWB: begin
            if (memValid) begin
               nextState = reqWrite ? RESPOND : FILL;   // stores skip the fetch
            end
         end
         FILL:     nextState = WAITFILL;
         WAITFILL: begin
            if (memValid) begin
               nextState = RESPOND;
            end
         end
         RESPOND:  nextState = IDLE;
         default:  nextState = IDLE;
      endcase
   end

   // state and line status bits
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         validArr <= '0;
         dirtyArr <= '0;
      end else begin
         state <= nextState;
         if (state == IDLE && access && tagHit && cacheReq.write) begin
            dirtyArr[newIdx] <= 1'b1;   // store hit
         end
         if (state == RESPOND && !respHit) begin
            validArr[reqIdx] <= 1'b1;
            dirtyArr[reqIdx] <= reqWrite;   // fresh store line is dirty
         end
      end
   end

   // request capture, data and tags
   always_ff @(posedge clk) begin
      if (state == IDLE && access) begin
         reqAddr  <= cacheReq.addr;
         reqWrite <= cacheReq.write;
         respHit  <= tagHit;
         if (cacheReq.write) begin
            lineData <= cacheReq.writeData;
         end else begin
            lineData <= dataArr[newIdx];   // replaced by the fill on a miss
         end
         if (tagHit && cacheReq.write) begin
            dataArr[newIdx] <= cacheReq.writeData;
         end
      end
      if (state == WAITFILL && memValid) begin
         lineData <= memReadData;
      end
      if (state == RESPOND && !respHit) begin
         dataArr[reqIdx] <= lineData;
         tagArr[reqIdx]  <= reqTag;
      end
   end

   assign memStart = (state == WRITEBACK) || (state == FILL);
   assign memWrite = (state == WRITEBACK);
   // victim address rebuilt from its tag
   assign memAddrOut = (state == WRITEBACK) ? {tagArr[reqIdx], reqIdx, 1'b0} : reqAddr;
   assign memData    = dataArr[reqIdx];   // victim word, still in place until RESPOND

   assign cacheDone = (state == RESPOND);
   assign cacheResp = '{readData: lineData, err: 1'b0, hit: respHit};

   // one memory access at a time, the next start waits for the answer
   assert property (@(posedge clk) disable iff (reset)
      memStart |=> (!memStart until_with memValid))
      else $error("dataCache: memStart while main memory busy");

endmodule

// File: mainMemory.sv
`timescale 1ns/1ps

module mainMemory #(
   parameter int MEM_LATENCY = 4,      // at least 1
   parameter int MEM_WORDS   = 4096
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            memStart,
   input  logic            memWrite,
   input  memPkg::memAddr  memAddrOut,
   input  memPkg::dataWord memData,
   output logic            memValid,
   output memPkg::dataWord memReadData
);
   import memPkg::*;

   localparam int WORD_BITS = $clog2(MEM_WORDS);
   localparam int CNT_BITS  = $clog2(MEM_LATENCY + 1);

   typedef logic [WORD_BITS-1:0] wordIndex;
   typedef logic [CNT_BITS-1:0]  latCount;

   dataWord storage [MEM_WORDS];   // contents undefined after reset

   logic     busy;        // access in service
   latCount  cnt;         // cycles left before the answer
   logic     pendWrite;   // captured request
   memAddr   pendAddr;
   dataWord  pendData;
   wordIndex wordIdx;

   assign wordIdx = pendAddr[WORD_BITS:1];   // low word-address bits only

   // answer MEM_LATENCY cycles after the start pulse
   assign memValid    = busy && (cnt == '0);
   assign memReadData = storage[wordIdx];

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (!busy) begin
         if (memStart) begin
            busy <= 1'b1;
            cnt  <= latCount'(MEM_LATENCY - 1);
         end
      end else if (cnt == '0) begin
         busy <= 1'b0;   // done, ready for the next start
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (memStart && !busy) begin   // starts while busy are dropped
         pendWrite <= memWrite;
         pendAddr  <= memAddrOut;
         pendData  <= memData;
      end
      if (memValid && pendWrite) begin
         storage[wordIdx] <= pendData;
      end
   end

   // each access answers once, and the next cannot start before the following cycle
   assert property (@(posedge clk) disable iff (reset) memValid |=> !memValid)
      else $error("mainMemory: memValid held for two cycles");

endmodule

// File: memWbReg.sv
`timescale 1ns/1ps

module memWbReg (
   input  logic           clk,
   input  logic           reset,
   input  logic           opDone,     // completion pulse from the memory stage
   input  memPkg::memResp stageResp,
   output logic           wbValid,    // one cycle after opDone
   output memPkg::memResp wbResp      // last completed operation
);

   // valid pulse into writeback
   always_ff @(posedge clk) begin
      if (reset) begin
         wbValid <= 1'b0;
      end else begin
         wbValid <= opDone;
      end
   end

   // held until the next completion
   always_ff @(posedge clk) begin
      if (opDone) begin
         wbResp <= stageResp;
      end
   end

endmodule

// File: memPipeTop.sv
`timescale 1ns/1ps

module memPipeTop #(
   parameter int CACHE_SETS  = 32,     // power of two
   parameter int MEM_LATENCY = 4,      // main memory cycles per access
   parameter int MEM_WORDS   = 4096
) (
   input  logic           clk,
   input  logic           reset,
   input  memPkg::memReq  req,
   output logic           stall,
   output logic           wbValid,
   output memPkg::memResp wbResp
);
   import memPkg::*;

   memReq   cacheReq;      // stage to cache
   memResp  cacheResp;
   logic    cacheDone;
   memResp  stageResp;     // stage to writeback register
   logic    opDone;
   logic    memStart;      // cache to main memory
   logic    memWrite;
   memAddr  memAddrOut;
   dataWord memData;
   logic    memValid;
   dataWord memReadData;

   memStage stage_i (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .cacheReq  (cacheReq),
      .cacheDone (cacheDone),
      .cacheResp (cacheResp),
      .stall     (stall),
      .opDone    (opDone),
      .stageResp (stageResp)
   );

   dataCache #(
      .CACHE_SETS (CACHE_SETS)
   ) cache_i (
      .clk         (clk),
      .reset       (reset),
      .cacheReq    (cacheReq),
      .cacheDone   (cacheDone),
      .cacheResp   (cacheResp),
      .memStart    (memStart),
      .memWrite    (memWrite),
      .memAddrOut  (memAddrOut),
      .memData     (memData),
      .memValid    (memValid),
      .memReadData (memReadData)
   );

   mainMemory #(
      .MEM_LATENCY (MEM_LATENCY),
      .MEM_WORDS   (MEM_WORDS)
   ) mem_i (
      .clk         (clk),
      .reset       (reset),
      .memStart    (memStart),
      .memWrite    (memWrite),
      .memAddrOut  (memAddrOut),
      .memData     (memData),
      .memValid    (memValid),
      .memReadData (memReadData)
   );

   memWbReg wb_i (
      .clk       (clk),
      .reset     (reset),
      .opDone    (opDone),
      .stageResp (stageResp),
      .wbValid   (wbValid),
      .wbResp    (wbResp)
   );

endmodule

// File: tbMemTasks.svh
// one request into the stage, released after the cycle where stall drops
task automatic doAccess(input memReq r, output memResp resp, output int lat,
                        output int stallCycles);
   logic released;
   logic stallNow;
   released    = 1'b0;
   lat         = 0;
   stallCycles = 0;
   @(posedge clk);
   req <= r;
   @(negedge clk);   // cycle 0
   while (!wbValid) begin
      stallNow = stall;
      if (stallNow) begin
         stallCycles++;
      end
      @(posedge clk);
      if (!released && !stallNow) begin
         req      <= NO_REQ;   // upstream advances
         released  = 1'b1;
      end
      lat++;
      @(negedge clk);
   end
   resp = wbResp;
endtask

// request checked against the reference model
task automatic runCheck(input memAddr addr, input dataWord wdata, input logic rd,
                        input logic wr);
   memReq  r;
   memResp exp;
   memResp resp;
   int     expLat;
   int     lat;
   int     stallCycles;
   r = '{addr: addr, writeData: wdata, read: rd, write: wr};
   predict(r, exp, expLat);
   doAccess(r, resp, lat, stallCycles);
   if (resp.err !== 1'b0) begin
      reportMismatch("wbResp.err", resp.err, 1'b0);
   end
   if (resp.hit !== exp.hit) begin
      reportMismatch("wbResp.hit", resp.hit, exp.hit);
   end
   if (rd && resp.readData !== exp.readData) begin   // store data not returned
      reportMismatch("wbResp.readData", resp.readData, exp.readData);
   end
   if (lat != expLat) begin
      reportMismatch("wbValid latency", lat, expLat);
   end
endtask

task automatic hitTimingTest();
   int     errsBefore;
   memReq  r;
   memResp exp;
   memResp resp;
   int     expLat;
   int     lat;
   int     stallCycles;
   errsBefore = errCount;
   if (stall !== 1'b0) begin
      reportMismatch("stall", stall, 1'b0);
   end
   runCheck(16'h0312, 16'h7E57, 1'b0, 1'b1);
   r = '{addr: 16'h0312, writeData: 16'h0000, read: 1'b1, write: 1'b0};
   predict(r, exp, expLat);   // keeps the model in step
   doAccess(r, resp, lat, stallCycles);
   if (lat != 2) begin
      reportMismatch("wbValid latency", lat, 2);
   end
   if (resp.hit !== 1'b1) begin
      reportMismatch("wbResp.hit", resp.hit, 1'b1);
   end
   if (resp.readData !== 16'h7E57) begin
      reportMismatch("wbResp.readData", resp.readData, 16'h7E57);
   end
   if (stallCycles != 1) begin
      reportMismatch("stall cycles", stallCycles, 1);
   end
   finishTest("hitTimingTest", errsBefore);
endtask

task automatic storeLoadTest();
   int errsBefore;
   errsBefore = errCount;
   runCheck(16'h0124, 16'hBEEF, 1'b0, 1'b1);   // cold set
   runCheck(16'h0124, 16'h0000, 1'b1, 1'b0);
   finishTest("storeLoadTest", errsBefore);
endtask

task automatic missConflictTest();
   int errsBefore;
   errsBefore = errCount;
   // three tags on set 5 push the first two out to main memory
   runCheck(16'h004A, 16'h1111, 1'b0, 1'b1);
   runCheck(16'h008A, 16'h2222, 1'b0, 1'b1);
   runCheck(16'h00CA, 16'h3333, 1'b0, 1'b1);
   runCheck(16'h004A, 16'h0000, 1'b1, 1'b0);   // miss, not cached
   runCheck(16'h004A, 16'h0000, 1'b1, 1'b0);   // repeat hits
   runCheck(16'h004A, 16'hABCD, 1'b0, 1'b1);   // store hit, line dirty
   runCheck(16'h008A, 16'h0000, 1'b1, 1'b0);   // conflict, dirty victim
   runCheck(16'h004A, 16'h0000, 1'b1, 1'b0);   // ABCD back from memory
   finishTest("missConflictTest", errsBefore);
endtask

task automatic misalignTest();
   int     errsBefore;
   memReq  r;
   memResp resp;
   int     lat;
   int     stallCycles;
   errsBefore = errCount;
   r = '{addr: 16'h0235, writeData: 16'h1234, read: 1'b1, write: 1'b0};
   doAccess(r, resp, lat, stallCycles);
   if (resp.err !== 1'b1) begin
      reportMismatch("wbResp.err", resp.err, 1'b1);
   end
   if (resp.readData !== 16'h0000) begin
      reportMismatch("wbResp.readData", resp.readData, 16'h0000);
   end
   if (resp.hit !== 1'b0) begin
      reportMismatch("wbResp.hit", resp.hit, 1'b0);
   end
   if (lat != 1) begin
      reportMismatch("wbValid latency", lat, 1);
   end
   if (stallCycles != 0) begin
      reportMismatch("stall cycles", stallCycles, 0);
   end
   finishTest("misalignTest", errsBefore);
endtask

task automatic noAccessTest();
   int    errsBefore;
   memReq r [2];
   errsBefore = errCount;
   r[0] = '{addr: BUBBLE_ADDR, writeData: 16'h5A5A, read: 1'b1, write: 1'b0};
   r[1] = '{addr: 16'h0124, writeData: 16'hA5A5, read: 1'b0, write: 1'b0};   // no strobe
   for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      req <= r[k];
      repeat (2 * MEM_LATENCY + 6) begin   // longer than a dirty read miss
         @(negedge clk);
         if (wbValid || stall) begin
            reportFailure("wbValid or stall raised by a request without an access");
         end
      end
      @(posedge clk);
      req <= NO_REQ;
   end
   runCheck(16'h0124, 16'h0000, 1'b1, 1'b0);   // real load still served
   finishTest("noAccessTest", errsBefore);
endtask

task automatic randomMixTest();
   int      errsBefore;
   int      rnd;
   memAddr  addr;
   dataWord wdata;
   memAddr  stored [$];   // words with known contents
   errsBefore = errCount;
   for (int n = 0; n < 40; n++) begin
      rnd   = $random(seed);
      addr  = memAddr'($random(seed)) & 16'h1FFE;   // aligned, inside 8 KB
      wdata = dataWord'($random(seed));
      if (rnd[0] && stored.size() > 0) begin
         addr = stored[$unsigned($random(seed)) % stored.size()];
         runCheck(addr, wdata, 1'b1, 1'b0);
      end else begin
         stored.push_back(addr);
         runCheck(addr, wdata, 1'b0, 1'b1);
      end
   end
   finishTest("randomMixTest", errsBefore);
endtask

// File: tbMemPipe.sv
`timescale 1ns/1ps

module tbMemPipe;
   import memPkg::*;

   localparam int CACHE_SETS     = 32;   // same as the DUT defaults
   localparam int MEM_LATENCY    = 4;
   localparam int INDEX_BITS     = $clog2(CACHE_SETS);
   localparam int REF_WORDS      = 4096;   // 8 KB of test addresses
   localparam int WORD_BITS      = $clog2(REF_WORDS);
   localparam int RESET_CYCLES   = 16;
   localparam int MAX_OPS        = 80;   // requests over all tests, rounded up
   // every op at worst a dirty read miss plus writeback and release
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + MAX_OPS * (2 * MEM_LATENCY + 6);

   localparam memReq NO_REQ = '{addr: '0, writeData: '0, read: 1'b0, write: 1'b0};

   logic   clk;
   logic   reset;
   memReq  req;
   logic   stall;
   logic   wbValid;
   memResp wbResp;

   int     errCount;
   int     testsRun;
   int     testsFailed;
   int     cycleCount;
   integer seed;

   // reference model, architectural memory plus a shadow of the cache tags
   dataWord               refMem [REF_WORDS];
   logic [15:0]           refTag [CACHE_SETS];
   logic [CACHE_SETS-1:0] refValid;
   logic [CACHE_SETS-1:0] refDirty;

   memPipeTop dut_i (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .stall   (stall),
      .wbValid (wbValid),
      .wbResp  (wbResp)
   );

   always #50 clk = ~clk;   // 100 ns period

   // expected response and cycles from request to wbValid, then model update
   task automatic predict(input memReq r, output memResp exp, output int expLat);
      int          idx;
      int          widx;
      logic [15:0] tag;
      logic        hit;
      idx  = int'(r.addr[INDEX_BITS:1]);
      widx = int'(r.addr[WORD_BITS:1]);
      tag  = r.addr >> (INDEX_BITS + 1);   // everything above the index
      hit  = refValid[idx] && (refTag[idx] == tag);
      if (r.write) begin
         refMem[widx] = r.writeData;
      end
      exp = '{readData: refMem[widx], err: 1'b0, hit: hit};
      if (hit) begin
         expLat = 2;   // done in cycle 1, writeback register adds one
      end else if (refValid[idx] && refDirty[idx]) begin
         expLat = r.read ? 2 * MEM_LATENCY + 4 : MEM_LATENCY + 3;   // victim out first
      end else begin
         expLat = r.read ? MEM_LATENCY + 3 : 2;   // store miss needs no fetch
      end
      if (hit) begin
         refDirty[idx] = refDirty[idx] | r.write;
      end else begin
         refValid[idx] = 1'b1;
         refTag[idx]   = tag;
         refDirty[idx] = r.write;
      end
   endtask

   task automatic reportMismatch(input string sigName, input logic [31:0] got,
                                 input logic [31:0] exp);
      $display("Mismatch %s: got %0h, expected %0h", sigName, got, exp);
      errCount++;
   endtask

   task automatic reportFailure(input string what);
      $display("Failure: %s", what);
      errCount++;
   endtask

   // one line per finished test
   task automatic finishTest(input string name, input int errsBefore);
      testsRun++;
      if (errCount == errsBefore) begin
         $display("%s: passed", name);
      end else begin
         testsFailed++;
         $display("%s: failed with %0d errors", name, errCount - errsBefore);
      end
   endtask

   `include "tbMemTasks.svh"

   // run limit
   initial begin
      cycleCount = 0;
      while (cycleCount < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("timeout after %0d cycles, a response never arrived", cycleCount);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      req         = NO_REQ;
      errCount    = 0;
      testsRun    = 0;
      testsFailed = 0;
      seed        = 32'he094;
      refValid    = '0;
      refDirty    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      hitTimingTest();   // first, stall is checked straight after reset
      storeLoadTest();
      missConflictTest();
      misalignTest();
      noAccessTest();
      randomMixTest();
      $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
      if (errCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+.
memPkg.sv
memStage.sv
dataCache.sv
mainMemory.sv
memWbReg.sv
memPipeTop.sv
tbMemPipe.sv

// File: Bender.yml
package:
  name: memPipe

sources:
  - memPkg.sv
  - memStage.sv
  - dataCache.sv
  - mainMemory.sv
  - memWbReg.sv
  - memPipeTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbMemPipe.sv
